// File: src/cpu_pkg.sv
package cpu_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;

	localparam logic [xlen-1:0]       reset_pc = 32'h0000_0000;
	localparam logic [reg_addr_w-1:0] link_reg = 5'd31; // jal/jalr link target

	// major opcodes
	localparam logic [5:0] op_special = 6'b000000;
	localparam logic [5:0] op_regimm  = 6'b000001;
	localparam logic [5:0] op_j       = 6'b000010;
	localparam logic [5:0] op_jal     = 6'b000011;
	localparam logic [5:0] op_beq     = 6'b000100;
	localparam logic [5:0] op_bne     = 6'b000101;
	localparam logic [5:0] op_blez    = 6'b000110;
	localparam logic [5:0] op_bgtz    = 6'b000111;
	localparam logic [5:0] op_addiu   = 6'b001001;
	localparam logic [5:0] op_slti    = 6'b001010;
	localparam logic [5:0] op_sltiu   = 6'b001011;
	localparam logic [5:0] op_andi    = 6'b001100;
	localparam logic [5:0] op_ori     = 6'b001101;
	localparam logic [5:0] op_xori    = 6'b001110;
	localparam logic [5:0] op_lui     = 6'b001111;
	localparam logic [5:0] op_lb      = 6'b100000;
	localparam logic [5:0] op_lw      = 6'b100011;
	localparam logic [5:0] op_lbu     = 6'b100100;
	localparam logic [5:0] op_sb      = 6'b101000;
	localparam logic [5:0] op_sw      = 6'b101011;

	// special function field
	localparam logic [5:0] fn_sll  = 6'b000000;
	localparam logic [5:0] fn_srl  = 6'b000010;
	localparam logic [5:0] fn_sra  = 6'b000011;
	localparam logic [5:0] fn_sllv = 6'b000100;
	localparam logic [5:0] fn_srlv = 6'b000110;
	localparam logic [5:0] fn_srav = 6'b000111;
	localparam logic [5:0] fn_jr   = 6'b001000;
	localparam logic [5:0] fn_jalr = 6'b001001;
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_xor  = 6'b100110;
	localparam logic [5:0] fn_nor  = 6'b100111;
	localparam logic [5:0] fn_slt  = 6'b101010;
	localparam logic [5:0] fn_sltu = 6'b101011;

	localparam logic [4:0] rt_bltz = 5'b00000; // regimm sub-codes in rt
	localparam logic [4:0] rt_bgez = 5'b00001;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_nor, alu_xor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
	} alu_op_e;

	typedef enum logic [3:0] {
		st_init, st_fetch, st_inst_wait, st_decode, st_execute,
		st_store, st_load, st_read_wait, st_write_back
	} cpu_state_e;

	typedef enum logic [1:0] {src1_rs, src1_shamt, src1_pc} src1_sel_e;
	typedef enum logic [1:0] {src2_rt, src2_simm, src2_zimm, src2_eight} src2_sel_e;

	// nine kinds, so one bit more than a 3-bit field allows
	typedef enum logic [3:0] {
		br_none, br_beq, br_bne, br_bgez, br_bgtz, br_blez, br_bltz,
		br_jump, br_jump_reg
	} br_kind_e;

	typedef struct packed {
		alu_op_e                 alu_op;
		src1_sel_e               src1_sel;
		src2_sel_e               src2_sel;
		br_kind_e                br_kind;
		logic                    reg_write;
		logic [reg_addr_w-1:0]   dest;
		logic                    is_load;
		logic                    is_store;
		logic                    byte_access;
		logic                    load_unsigned;
	} ctrl_t;

	typedef struct packed {
		logic            read;
		logic            write;
		logic [3:0]      strb;
		logic [xlen-1:0] addr; // word aligned
		logic [xlen-1:0] wdata;
	} mem_req_t;

endpackage

// File: src/inst_decode.sv
`timescale 1ns/10ps

module inst_decode (
	input  logic [cpu_pkg::xlen-1:0] inst,
	output cpu_pkg::ctrl_t           dec
);
	import cpu_pkg::*;

	logic [5:0] opcode;
	logic [4:0] rs, rt, rd, sa;
	logic [5:0] funct;

	assign opcode = inst[31:26];
	assign rs     = inst[25:21];
	assign rt     = inst[20:16];
	assign rd     = inst[15:11];
	assign sa     = inst[10:6];
	assign funct  = inst[5:0];

	always_comb begin
		dec.alu_op        = alu_add;
		dec.src1_sel      = src1_rs;
		dec.src2_sel      = src2_rt;
		dec.br_kind       = br_none;
		dec.reg_write     = 1'b0; // unknown words fall through as a nop
		dec.dest          = rd;
		dec.is_load       = 1'b0;
		dec.is_store      = 1'b0;
		dec.byte_access   = 1'b0;
		dec.load_unsigned = 1'b0;
		case (opcode)
			op_special: begin
				case (funct)
					fn_sll: begin
						dec.alu_op    = alu_sll;
						dec.src1_sel  = src1_shamt;
						dec.reg_write = rs == 5'd0;
					end
					fn_srl: begin
						dec.alu_op    = alu_srl;
						dec.src1_sel  = src1_shamt;
						dec.reg_write = rs == 5'd0;
					end
					fn_sra: begin
						dec.alu_op    = alu_sra;
						dec.src1_sel  = src1_shamt;
						dec.reg_write = rs == 5'd0;
					end
					fn_sllv: {dec.alu_op, dec.reg_write} = {alu_sll, sa == 5'd0};
					fn_srlv: {dec.alu_op, dec.reg_write} = {alu_srl, sa == 5'd0};
					fn_srav: {dec.alu_op, dec.reg_write} = {alu_sra, sa == 5'd0};
					fn_addu: {dec.alu_op, dec.reg_write} = {alu_add, sa == 5'd0};
					fn_subu: {dec.alu_op, dec.reg_write} = {alu_sub, sa == 5'd0};
					fn_and:  {dec.alu_op, dec.reg_write} = {alu_and, sa == 5'd0};
					fn_or:   {dec.alu_op, dec.reg_write} = {alu_or, sa == 5'd0};
					fn_xor:  {dec.alu_op, dec.reg_write} = {alu_xor, sa == 5'd0};
					fn_nor:  {dec.alu_op, dec.reg_write} = {alu_nor, sa == 5'd0};
					fn_slt:  {dec.alu_op, dec.reg_write} = {alu_slt, sa == 5'd0};
					fn_sltu: {dec.alu_op, dec.reg_write} = {alu_sltu, sa == 5'd0};
					fn_jr: begin
						if (rt == 5'd0 && rd == 5'd0)
							dec.br_kind = br_jump_reg;
					end
					fn_jalr: begin
						if (rt == 5'd0) begin
							dec.br_kind   = br_jump_reg;
							dec.reg_write = 1'b1;
							dec.dest      = link_reg;
							dec.src1_sel  = src1_pc; // link = pc + 8
							dec.src2_sel  = src2_eight;
						end
					end
					default: ;
				endcase
			end
			op_regimm: begin
				if (rt == rt_bltz)
					dec.br_kind = br_bltz;
				else if (rt == rt_bgez)
					dec.br_kind = br_bgez;
			end
			op_j: dec.br_kind = br_jump;
			op_jal: begin
				dec.br_kind   = br_jump;
				dec.reg_write = 1'b1;
				dec.dest      = link_reg;
				dec.src1_sel  = src1_pc;
				dec.src2_sel  = src2_eight;
			end
			op_beq:  dec.br_kind = br_beq;
			op_bne:  dec.br_kind = br_bne;
			op_blez: dec.br_kind = rt == 5'd0 ? br_blez : br_none;
			op_bgtz: dec.br_kind = rt == 5'd0 ? br_bgtz : br_none;
			op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori: begin
				dec.reg_write = 1'b1;
				dec.dest      = rt;
				case (opcode)
					op_slti:  {dec.alu_op, dec.src2_sel} = {alu_slt, src2_simm};
					op_sltiu: {dec.alu_op, dec.src2_sel} = {alu_sltu, src2_simm};
					op_andi:  {dec.alu_op, dec.src2_sel} = {alu_and, src2_zimm};
					op_ori:   {dec.alu_op, dec.src2_sel} = {alu_or, src2_zimm};
					op_xori:  {dec.alu_op, dec.src2_sel} = {alu_xor, src2_zimm};
					default:  {dec.alu_op, dec.src2_sel} = {alu_add, src2_simm};
				endcase
			end
			op_lui: begin
				dec.alu_op    = alu_lui;
				dec.src2_sel  = src2_zimm;
				dec.reg_write = rs == 5'd0;
				dec.dest      = rt;
			end
			op_lw, op_lb, op_lbu: begin
				dec.src2_sel      = src2_simm; // base + offset
				dec.reg_write     = 1'b1;
				dec.dest          = rt;
				dec.is_load       = 1'b1;
				dec.byte_access   = opcode != op_lw;
				dec.load_unsigned = opcode == op_lbu;
			end
			op_sw, op_sb: begin
				dec.src2_sel    = src2_simm;
				dec.is_store    = 1'b1;
				dec.byte_access = opcode == op_sb;
			end
			default: ;
		endcase
	end

endmodule

// File: src/alu.sv
`timescale 1ns/10ps

module alu (
	input  logic [cpu_pkg::xlen-1:0] a,
	input  logic [cpu_pkg::xlen-1:0] b,
	input  cpu_pkg::alu_op_e         op,
	output logic [cpu_pkg::xlen-1:0] result
);
	import cpu_pkg::*;

	logic [4:0] shamt;

	assign shamt = a[4:0]; // shift amount always comes in on a

	always_comb begin
		case (op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_nor:  result = ~(a | b);
			alu_xor:  result = a ^ b;
			alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
			alu_sll:  result = b << shamt;
			alu_srl:  result = b >> shamt;
			alu_sra:  result = $signed(b) >>> shamt;
			alu_lui:  result = b << 16;
			default:  result = '0;
		endcase
	end

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
	input  logic [cpu_pkg::reg_addr_w-1:0] raddr2,
	input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
	input  logic                           wen,
	input  logic [cpu_pkg::xlen-1:0]       wdata,
	output logic [cpu_pkg::xlen-1:0]       rdata1,
	output logic [cpu_pkg::xlen-1:0]       rdata2
);
	import cpu_pkg::*;

	logic [xlen-1:0] regs [1 << reg_addr_w];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < (1 << reg_addr_w); i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = raddr1 == '0 ? '0 : regs[raddr1]; // r0 reads zero
	assign rdata2 = raddr2 == '0 ? '0 : regs[raddr2];

endmodule

// File: src/cycle_ctrl.sv
`timescale 1ns/10ps

module cycle_ctrl (
	input  logic                 clk,
	input  logic                 rst,
	input  cpu_pkg::ctrl_t       dec,
	input  logic                 inst_req_ack,
	input  logic                 inst_valid,
	input  logic                 mem_req_ack,
	input  logic                 read_data_valid,
	output cpu_pkg::cpu_state_e  state,
	output logic                 inst_req_valid,
	output logic                 inst_ack,
	output logic                 mem_read,
	output logic                 mem_write,
	output logic                 read_data_ack
);
	import cpu_pkg::*;

	cpu_state_e state_nx;

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_init;
		else
			state <= state_nx;
	end

	always_comb begin
		state_nx = state;
		case (state)
			st_init: state_nx = st_fetch;
			st_fetch: begin
				if (inst_req_valid && inst_req_ack)
					state_nx = st_inst_wait;
			end
			st_inst_wait: begin
				if (inst_ack && inst_valid)
					state_nx = st_decode;
			end
			st_decode: state_nx = st_execute;
			st_execute: begin
				if (dec.is_store)
					state_nx = st_store;
				else if (dec.is_load)
					state_nx = st_load;
				else if (dec.reg_write)
					state_nx = st_write_back; // alu ops, jal, jalr
				else
					state_nx = st_fetch; // j, jr, branches and nops
			end
			st_store: begin
				if (mem_write && mem_req_ack)
					state_nx = st_fetch;
			end
			st_load: begin
				if (mem_read && mem_req_ack)
					state_nx = st_read_wait;
			end
			st_read_wait: begin
				if (read_data_ack && read_data_valid)
					state_nx = st_write_back;
			end
			st_write_back: state_nx = st_fetch;
			default: state_nx = st_init;
		endcase
	end

	// handshake strobes depend on the state alone
	assign inst_req_valid = state == st_fetch;
	assign inst_ack       = state == st_inst_wait;
	assign mem_write      = state == st_store;
	assign mem_read       = state == st_load;
	assign read_data_ack  = state == st_read_wait;

endmodule

// File: src/byte_lane.sv
`timescale 1ns/10ps

module byte_lane (
	input  logic [1:0]               addr_low,
	input  logic                     byte_access,
	input  logic                     load_unsigned,
	input  logic [cpu_pkg::xlen-1:0] store_data,
	input  logic [cpu_pkg::xlen-1:0] mem_word,
	output logic [3:0]               strb,
	output logic [cpu_pkg::xlen-1:0] wdata,
	output logic [cpu_pkg::xlen-1:0] load_result
);
	import cpu_pkg::*;

	logic [7:0] ld_byte;
	logic       ld_sign;

	// store side: byte is replicated, strobe picks the lane
	assign strb  = byte_access ? 4'b0001 << addr_low : 4'b1111;
	assign wdata = byte_access ? {4{store_data[7:0]}} : store_data;

	assign ld_byte = mem_word[{addr_low, 3'b000} +: 8];
	assign ld_sign = ld_byte[7] & ~load_unsigned; // lbu zero extends

	always_comb begin
		if (byte_access)
			load_result = {{(xlen-8){ld_sign}}, ld_byte};
		else
			load_result = mem_word;
	end

endmodule

// File: src/mips_cpu.sv
`timescale 1ns/10ps

module mips_cpu (
	input  logic                     clk,
	input  logic                     rst,
	output logic [cpu_pkg::xlen-1:0] pc,
	output logic                     inst_req_valid,
	input  logic                     inst_req_ack,
	input  logic [cpu_pkg::xlen-1:0] instruction,
	input  logic                     inst_valid,
	output logic                     inst_ack,
	output cpu_pkg::mem_req_t        mem_req,
	input  logic                     mem_req_ack,
	input  logic [cpu_pkg::xlen-1:0] read_data,
	input  logic                     read_data_valid,
	output logic                     read_data_ack
);
	import cpu_pkg::*;

	cpu_state_e      state;
	ctrl_t           dec;
	logic            mem_read, mem_write;
	logic [xlen-1:0] next_pc, pc_plus4, br_target;
	logic            br_taken, pc_load;
	logic [xlen-1:0] inst_reg, rdata_reg;
	logic [4:0]      rs, rt, sa;
	logic [15:0]     imm;
	logic [xlen-1:0] rs_value, rt_value;
	logic [xlen-1:0] alu_a, alu_b, alu_result, rf_wdata;
	logic [3:0]      lane_strb;
	logic [xlen-1:0] lane_wdata, load_result;

	assign rs  = inst_reg[25:21];
	assign rt  = inst_reg[20:16];
	assign sa  = inst_reg[10:6];
	assign imm = inst_reg[15:0];

	cycle_ctrl u_ctrl (
		.clk, .rst, .dec, .inst_req_ack, .inst_valid, .mem_req_ack, .read_data_valid,
		.state, .inst_req_valid, .inst_ack, .mem_read, .mem_write, .read_data_ack
	);

	inst_decode u_dec (.inst(inst_reg), .dec);

	reg_file u_rf (
		.clk, .rst, .raddr1(rs), .raddr2(rt), .waddr(dec.dest),
		.wen(dec.reg_write && state == st_write_back),
		.wdata(rf_wdata), .rdata1(rs_value), .rdata2(rt_value)
	);

	alu u_alu (.a(alu_a), .b(alu_b), .op(dec.alu_op), .result(alu_result));

	byte_lane u_lane (
		.addr_low(alu_result[1:0]), .byte_access(dec.byte_access),
		.load_unsigned(dec.load_unsigned), .store_data(rt_value), .mem_word(rdata_reg),
		.strb(lane_strb), .wdata(lane_wdata), .load_result(load_result)
	);

	// branch resolution, used in decode
	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		case (dec.br_kind)
			br_beq:  br_taken = rs_value == rt_value;
			br_bne:  br_taken = rs_value != rt_value;
			br_bgez: br_taken = ~rs_value[31];
			br_bgtz: br_taken = ~rs_value[31] && rs_value != '0;
			br_blez: br_taken = rs_value[31] || rs_value == '0;
			br_bltz: br_taken = rs_value[31];
			br_jump, br_jump_reg: br_taken = 1'b1;
			default: br_taken = 1'b0;
		endcase
		case (dec.br_kind)
			br_jump:     br_target = {pc[31:28], inst_reg[25:0], 2'b00};
			br_jump_reg: br_target = rs_value;
			default:     br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00}; // no delay slot
		endcase
	end

	// pc moves only when the FSM is about to enter fetch
	assign pc_load = state == st_write_back || (mem_write && mem_req_ack) ||
		(state == st_execute && !dec.is_store && !dec.is_load && !dec.reg_write);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc      <= reset_pc;
			next_pc <= reset_pc;
		end else begin
			if (state == st_decode)
				next_pc <= br_taken ? br_target : pc_plus4;
			if (pc_load)
				pc <= next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_ack && inst_valid)
			inst_reg <= instruction;
		if (read_data_ack && read_data_valid)
			rdata_reg <= read_data;
	end

	always_comb begin
		case (dec.src1_sel)
			src1_shamt: alu_a = {{(xlen-5){1'b0}}, sa};
			src1_pc:    alu_a = pc;
			default:    alu_a = rs_value;
		endcase
		case (dec.src2_sel)
			src2_simm:  alu_b = {{16{imm[15]}}, imm};
			src2_zimm:  alu_b = {16'h0000, imm};
			src2_eight: alu_b = 32'd8; // pc + 8 link
			default:    alu_b = rt_value;
		endcase
	end

	assign rf_wdata = dec.is_load ? load_result : alu_result;

	always_comb begin
		mem_req.read  = mem_read;
		mem_req.write = mem_write;
		mem_req.strb  = mem_write ? lane_strb : 4'b0000;
		mem_req.addr  = {alu_result[31:2], 2'b00};
		mem_req.wdata = lane_wdata;
	end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: bench/mips_tb_sva.sv
`timescale 1ns/10ps

module mips_tb_sva (
	input logic                     clk,
	input logic                     rst,
	input logic [cpu_pkg::xlen-1:0] pc,
	input logic                     inst_req_valid,
	input logic                     inst_req_ack,
	input cpu_pkg::mem_req_t        mem_req,
	input logic                     mem_req_ack
);
	inst_req_held: assert property (@(posedge clk) disable iff (rst)
		inst_req_valid && !inst_req_ack |=> inst_req_valid && $stable(pc))
		else $error("instruction request changed before its ack");

	// whole data request, strobes and wdata included
	mem_req_held: assert property (@(posedge clk) disable iff (rst)
		(mem_req.read || mem_req.write) && !mem_req_ack |=> $stable(mem_req))
		else $error("data request changed before its ack");

	one_direction: assert property (@(posedge clk) disable iff (rst)
		!(mem_req.read && mem_req.write))
		else $error("read and write requested together");

	strb_after_reset: assert property (@(posedge clk) rst |=> mem_req.strb == 4'b0000)
		else $error("byte strobes active right after reset");

endmodule

bind mips_cpu mips_tb_sva sva (
	.clk, .rst, .pc, .inst_req_valid, .inst_req_ack, .mem_req, .mem_req_ack
);

// File: bench/mips_tb.sv
`timescale 1ns/10ps

module mips_tb;
	import cpu_pkg::*;

	localparam int n_inst      = 200;
	localparam int n_rand      = 168; // followed by 31 register stores and the final loop
	localparam int cycle_limit = n_inst * 20;
	localparam logic [31:0] end_addr = 32'((n_inst - 1) * 4);

	logic        clk, rst;
	logic [31:0] pc, instruction, read_data;
	logic        inst_req_valid, inst_req_ack, inst_valid, inst_ack;
	mem_req_t    mem_req;
	logic        mem_req_ack, read_data_valid, read_data_ack;

	logic [31:0] imem [256];
	logic [31:0] dmem [256]; // what the core sees
	logic [31:0] mdm [256];  // model copy
	logic [31:0] mreg [32];
	logic [31:0] mpc;
	logic [31:0] seed;
	logic        is_target [256];
	logic        exp_read, exp_write;
	logic [3:0]  exp_strb;
	logic [31:0] exp_addr, exp_wdata;
	int          errors;
	int          cycles;
	logic        done;

	tb_clock u_clk (.clk, .rst);

	mips_cpu dut (.*);

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r[30:8]) % n;
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [31:0] r;
		r = next_rand();
		return r[20:16];
	endfunction

	function automatic logic [15:0] rand_imm();
		logic [31:0] r;
		r = next_rand();
		return r[23:8];
	endfunction

	function automatic logic [31:0] r_type(input logic [4:0] rs, rt, rd, sa,
		input logic [5:0] fn);
		return {op_special, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word, new_word,
		input logic [3:0] strb);
		logic [31:0] res;
		res = old_word;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		return res;
	endfunction

	// forward only, never past the start of the store block
	function automatic int fwd_target(input int i, input int span);
		int t;
		t = i + 1 + rand_below(span);
		if (t > n_rand)
			t = n_rand;
		return t;
	endfunction

	task automatic check(input string what, input logic [31:0] expected, actual);
		if (expected !== actual) begin
			errors++;
			$display("** Error at %0t: %s expected %h, got %h", $time, what, expected, actual);
		end
	endtask

	task automatic report(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic put(input int idx, input logic [31:0] word);
		imem[8'(idx)] = word;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic build_program();
		int          i, t;
		logic [4:0]  rk;
		logic [5:0]  fn, op;
		i = 0;
		while (i < n_rand) begin
			case (rand_below(16))
				0, 1, 2, 3, 4, 5: begin
					case (rand_below(11))
						0: fn = fn_addu;
						1: fn = fn_subu;
						2: fn = fn_and;
						3: fn = fn_or;
						4: fn = fn_xor;
						5: fn = fn_nor;
						6: fn = fn_slt;
						7: fn = fn_sltu;
						8: fn = fn_sllv;
						9: fn = fn_srlv;
						default: fn = fn_srav;
					endcase
					put(i, r_type(rand_reg(), rand_reg(), rand_reg(), 5'd0, fn));
				end
				6: begin
					case (rand_below(3))
						0: fn = fn_sll;
						1: fn = fn_srl;
						default: fn = fn_sra;
					endcase
					put(i, r_type(5'd0, rand_reg(), rand_reg(), 5'(rand_below(32)), fn));
				end
				7, 8: begin
					case (rand_below(7))
						0: op = op_addiu;
						1: op = op_slti;
						2: op = op_sltiu;
						3: op = op_andi;
						4: op = op_ori;
						5: op = op_xori;
						default: op = op_lui;
					endcase
					put(i, i_type(op, op == op_lui ? 5'd0 : rand_reg(), rand_reg(), rand_imm()));
				end
				9: begin
					case (rand_below(3))
						0: put(i, i_type(op_lw, 5'd0, rand_reg(), 16'(rand_below(128) * 4)));
						1: put(i, i_type(op_lb, 5'd0, rand_reg(), 16'(rand_below(512))));
						default: put(i, i_type(op_lbu, 5'd0, rand_reg(), 16'(rand_below(512))));
					endcase
				end
				10: begin
					if (rand_below(2) == 0)
						put(i, i_type(op_sw, 5'd0, rand_reg(), 16'(rand_below(128) * 4)));
					else
						put(i, i_type(op_sb, 5'd0, rand_reg(), 16'(rand_below(512))));
				end
				11, 12: begin
					t = fwd_target(i, 6);
					is_target[8'(t)] = 1'b1;
					case (rand_below(6))
						0: put(i, i_type(op_beq, rand_reg(), rand_reg(), 16'(t - i - 1)));
						1: put(i, i_type(op_bne, rand_reg(), rand_reg(), 16'(t - i - 1)));
						2: put(i, i_type(op_blez, rand_reg(), 5'd0, 16'(t - i - 1)));
						3: put(i, i_type(op_bgtz, rand_reg(), 5'd0, 16'(t - i - 1)));
						4: put(i, i_type(op_regimm, rand_reg(), rt_bltz, 16'(t - i - 1)));
						default: put(i, i_type(op_regimm, rand_reg(), rt_bgez, 16'(t - i - 1)));
					endcase
				end
				13: begin
					t = fwd_target(i, 8);
					is_target[8'(t)] = 1'b1;
					put(i, {rand_below(2) == 0 ? op_j : op_jal, 26'(t)});
				end
				14: begin
					// ori then jr/jalr, never entered in the middle
					if (i + 1 < n_rand && !is_target[8'(i + 1)]) begin
						t = fwd_target(i + 1, 6);
						is_target[8'(t)] = 1'b1;
						rk = 5'(1 + rand_below(30));
						put(i, i_type(op_ori, 5'd0, rk, 16'(t * 4)));
						if (rand_below(2) == 0)
							put(i + 1, r_type(rk, 5'd0, 5'd0, 5'd0, fn_jr));
						else
							put(i + 1, r_type(rk, 5'd0, 5'd31, 5'd0, fn_jalr));
						i++;
					end else begin
						put(i, i_type(op_addiu, rand_reg(), rand_reg(), rand_imm()));
					end
				end
				default: put(i, i_type(op_addiu, rand_reg(), rand_reg(), rand_imm()));
			endcase
			i++;
		end
		for (int r = 1; r < 32; r++)
			put(n_rand + r - 1, i_type(op_sw, 5'd0, 5'(r), 16'(512 + 4 * r)));
		put(n_inst - 1, i_type(op_beq, 5'd0, 5'd0, 16'hffff)); // branch to itself
	endtask

	task automatic set_reg(input logic [4:0] r, input logic [31:0] v);
		if (r != 5'd0)
			mreg[r] = v;
	endtask

	// executes the instruction at mpc and records the data access it makes
	task automatic model_step();
		logic [31:0] inst, rs_v, rt_v, simm, zimm, addr, word, npc, brt;
		logic [7:0]  ld_byte;
		logic [4:0]  rs, rt, rd, sa;
		logic [5:0]  op, fn;
		inst = imem[mpc[9:2]];
		op   = inst[31:26];
		rs   = inst[25:21];
		rt   = inst[20:16];
		rd   = inst[15:11];
		sa   = inst[10:6];
		fn   = inst[5:0];
		rs_v = mreg[rs];
		rt_v = mreg[rt];
		simm = {{16{inst[15]}}, inst[15:0]};
		zimm = {16'h0000, inst[15:0]};
		npc  = mpc + 32'd4;
		brt  = npc + {simm[29:0], 2'b00};
		addr = rs_v + simm;
		word = mdm[addr[9:2]];
		ld_byte = word[8*addr[1:0] +: 8];
		case (op)
			op_special: begin
				case (fn)
					fn_sll:  set_reg(rd, rt_v << sa);
					fn_srl:  set_reg(rd, rt_v >> sa);
					fn_sra:  set_reg(rd, $signed(rt_v) >>> sa);
					fn_sllv: set_reg(rd, rt_v << rs_v[4:0]);
					fn_srlv: set_reg(rd, rt_v >> rs_v[4:0]);
					fn_srav: set_reg(rd, $signed(rt_v) >>> rs_v[4:0]);
					fn_addu: set_reg(rd, rs_v + rt_v);
					fn_subu: set_reg(rd, rs_v - rt_v);
					fn_and:  set_reg(rd, rs_v & rt_v);
					fn_or:   set_reg(rd, rs_v | rt_v);
					fn_xor:  set_reg(rd, rs_v ^ rt_v);
					fn_nor:  set_reg(rd, ~(rs_v | rt_v));
					fn_slt:  set_reg(rd, {31'd0, $signed(rs_v) < $signed(rt_v)});
					fn_sltu: set_reg(rd, {31'd0, rs_v < rt_v});
					fn_jr:   npc = rs_v;
					fn_jalr: begin
						npc = rs_v;
						set_reg(5'd31, mpc + 32'd8);
					end
					default: ;
				endcase
			end
			op_regimm: begin
				if (rt == rt_bltz && rs_v[31])
					npc = brt;
				else if (rt == rt_bgez && !rs_v[31])
					npc = brt;
			end
			op_j:    npc = {mpc[31:28], inst[25:0], 2'b00};
			op_jal: begin
				npc = {mpc[31:28], inst[25:0], 2'b00};
				set_reg(5'd31, mpc + 32'd8);
			end
			op_beq:  if (rs_v == rt_v) npc = brt;
			op_bne:  if (rs_v != rt_v) npc = brt;
			op_blez: if ($signed(rs_v) <= 0) npc = brt;
			op_bgtz: if ($signed(rs_v) > 0) npc = brt;
			op_addiu: set_reg(rt, rs_v + simm);
			op_slti:  set_reg(rt, {31'd0, $signed(rs_v) < $signed(simm)});
			op_sltiu: set_reg(rt, {31'd0, rs_v < simm});
			op_andi:  set_reg(rt, rs_v & zimm);
			op_ori:   set_reg(rt, rs_v | zimm);
			op_xori:  set_reg(rt, rs_v ^ zimm);
			op_lui:   set_reg(rt, {inst[15:0], 16'h0000});
			op_lw, op_lb, op_lbu: begin
				exp_read = 1'b1;
				exp_addr = {addr[31:2], 2'b00};
				if (op == op_lw)
					set_reg(rt, word);
				else if (op == op_lb)
					set_reg(rt, {{24{ld_byte[7]}}, ld_byte});
				else
					set_reg(rt, {24'd0, ld_byte});
			end
			op_sw, op_sb: begin
				exp_write = 1'b1;
				exp_addr  = {addr[31:2], 2'b00};
				exp_strb  = op == op_sw ? 4'b1111 : 4'b0001 << addr[1:0];
				exp_wdata = op == op_sw ? rt_v : {4{rt_v[7:0]}};
				mdm[addr[9:2]] = merge_bytes(word, exp_wdata, exp_strb);
			end
			default: ;
		endcase
		mpc = npc;
	endtask

	task automatic fetch_seen();
		if (exp_read || exp_write)
			report("the core fetched again without making the expected data access");
		exp_read  = 1'b0;
		exp_write = 1'b0;
		check("fetch pc", mpc, pc);
		if (pc == end_addr || mpc == end_addr)
			done = 1'b1;
		else
			model_step();
	endtask

	task automatic data_seen();
		check("request read", 32'(exp_read), 32'(mem_req.read));
		check("request write", 32'(exp_write), 32'(mem_req.write));
		check("request address", exp_addr, mem_req.addr);
		if (mem_req.write) begin
			check("write strobes", 32'(exp_strb), 32'(mem_req.strb));
			check("write data", exp_wdata, mem_req.wdata);
		end
		exp_read  = 1'b0;
		exp_write = 1'b0;
	endtask

	always @(posedge clk)
		cycles <= cycles + 1;

	always @(negedge clk)
		if (rst && (inst_req_valid || mem_req.read || mem_req.write))
			report("the core raised a request while reset was high");

	// instruction memory side
	initial forever begin
		@(negedge clk);
		if (!rst && inst_req_valid && !done) begin
			wait_cycles(rand_below(4));
			fetch_seen();
			inst_req_ack = 1'b1;
			@(negedge clk);
			inst_req_ack = 1'b0;
			wait_cycles(rand_below(4));
			instruction = imem[pc[9:2]];
			inst_valid  = 1'b1;
			check("instruction ack", 32'd1, 32'(inst_ack));
			@(negedge clk);
			inst_valid = 1'b0;
		end
	end

	// data memory side
	initial begin : data_side
		logic        rd;
		logic [31:0] a;
		forever begin
			@(negedge clk);
			if (!rst && (mem_req.read || mem_req.write)) begin
				wait_cycles(rand_below(4));
				data_seen();
				rd = mem_req.read;
				a  = mem_req.addr;
				if (mem_req.write)
					dmem[a[9:2]] = merge_bytes(dmem[a[9:2]], mem_req.wdata, mem_req.strb);
				mem_req_ack = 1'b1;
				@(negedge clk);
				mem_req_ack = 1'b0;
				if (rd) begin
					wait_cycles(rand_below(4));
					read_data       = dmem[a[9:2]];
					read_data_valid = 1'b1;
					check("read data ack", 32'd1, 32'(read_data_ack));
					@(negedge clk);
					read_data_valid = 1'b0;
				end
			end
		end
	end

	initial begin
		inst_req_ack    = 1'b0;
		instruction     = '0;
		inst_valid      = 1'b0;
		mem_req_ack     = 1'b0;
		read_data       = '0;
		read_data_valid = 1'b0;
		seed      = 32'hfd86_ccce;
		errors    = 0;
		cycles    = 0;
		done      = 1'b0;
		exp_read  = 1'b0;
		exp_write = 1'b0;
		exp_strb  = '0;
		exp_addr  = '0;
		exp_wdata = '0;
		mpc       = reset_pc;
		for (int a = 0; a < 256; a++) begin
			dmem[8'(a)] = (32'(a) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f; // scrambled word per address
			mdm[8'(a)]  = dmem[8'(a)];
			imem[8'(a)] = '0;
			is_target[8'(a)] = 1'b0;
		end
		for (int r = 0; r < 32; r++)
			mreg[5'(r)] = '0;
		build_program();
		while (!done && cycles < cycle_limit)
			@(posedge clk);
		if (!done)
			report($sformatf("the program did not finish within %0d cycles", cycle_limit));
		$display("run ended after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: tb.f
src/cpu_pkg.sv
src/inst_decode.sv
src/alu.sv
src/reg_file.sv
src/cycle_ctrl.sv
src/byte_lane.sv
src/mips_cpu.sv
bench/tb_clock.sv
bench/mips_tb_sva.sv
bench/mips_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_tb -f tb.f -o mips_sim

out=$(./obj_dir/mips_sim || true)
echo "$out"

if grep -qx "SIMULATION PASSED" <<< "$out"; then
	exit 0
else
	exit 1
fi
